// ==== decode_pkg.sv ====
`default_nettype none

package decode_pkg;

	localparam int insn_width = 32;
	localparam int reg_index_width = 5;
	localparam int reg_count = 32;
	localparam int stack_reg = 29;	// Stack pointer

	// Major opcodes
	localparam logic [5:0] r_type = 6'b000000;
	localparam logic [5:0] mul_op = 6'b011100;
	localparam logic [5:0] regimm = 6'b000001;
	localparam logic [5:0] addi = 6'b001000;
	localparam logic [5:0] addiu = 6'b001001;
	localparam logic [5:0] slti = 6'b001010;
	localparam logic [5:0] sltiu = 6'b001011;
	localparam logic [5:0] ori = 6'b001101;
	localparam logic [5:0] xori = 6'b001110;
	localparam logic [5:0] lui = 6'b001111;
	localparam logic [5:0] lw = 6'b100011;
	localparam logic [5:0] sw = 6'b101011;
	localparam logic [5:0] lb = 6'b100000;
	localparam logic [5:0] lbu = 6'b100100;
	localparam logic [5:0] sb = 6'b101000;
	localparam logic [5:0] beq = 6'b000100;
	localparam logic [5:0] bne = 6'b000101;
	localparam logic [5:0] blez = 6'b000110;
	localparam logic [5:0] bgtz = 6'b000111;
	localparam logic [5:0] j = 6'b000010;
	localparam logic [5:0] jal = 6'b000011;

	// R-type function field
	localparam logic [5:0] add_func = 6'b100000;
	localparam logic [5:0] addu_func = 6'b100001;
	localparam logic [5:0] sub_func = 6'b100010;
	localparam logic [5:0] subu_func = 6'b100011;
	localparam logic [5:0] mult_func = 6'b011000;
	localparam logic [5:0] multu_func = 6'b011001;
	localparam logic [5:0] div_func = 6'b011010;
	localparam logic [5:0] divu_func = 6'b011011;
	localparam logic [5:0] mfhi_func = 6'b010000;
	localparam logic [5:0] mflo_func = 6'b010010;
	localparam logic [5:0] slt_func = 6'b101010;
	localparam logic [5:0] sltu_func = 6'b101011;
	localparam logic [5:0] sll_func = 6'b000000;
	localparam logic [5:0] sllv_func = 6'b000100;
	localparam logic [5:0] srl_func = 6'b000010;
	localparam logic [5:0] srlv_func = 6'b000110;
	localparam logic [5:0] sra_func = 6'b000011;
	localparam logic [5:0] srav_func = 6'b000111;
	localparam logic [5:0] and_func = 6'b100100;
	localparam logic [5:0] or_func = 6'b100101;
	localparam logic [5:0] xor_func = 6'b100110;
	localparam logic [5:0] nor_func = 6'b100111;
	localparam logic [5:0] jalr_func = 6'b001001;
	localparam logic [5:0] jr_func = 6'b001000;
	localparam logic [5:0] mul_func = 6'b000010;	// Only under mul_op

	// REGIMM rt field
	localparam logic [4:0] bltz = 5'b00000;
	localparam logic [4:0] bgez = 5'b00001;

	typedef enum logic [2:0] {
		class_r,	// Encoding zero, reset value
		class_i,
		class_regimm,
		class_j,
		class_none
	} insn_class_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [reg_index_width-1:0] rs;
		logic [reg_index_width-1:0] rt;
		logic [reg_index_width-1:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} insn_r_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [reg_index_width-1:0] rs;
		logic [reg_index_width-1:0] rt;
		logic [15:0] imm16;
	} insn_i_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [25:0] target26;
	} insn_j_t;

	typedef union packed {
		insn_r_t r;
		insn_i_t i;
		insn_j_t j;
	} insn_word_t;

endpackage

`default_nettype wire

// ==== insn_classify.sv ====
`timescale 1ns/1ps
`default_nettype none

module insn_classify (
	input decode_pkg::insn_word_t insn,
	output logic valid,
	output decode_pkg::insn_class_t insn_class,
	output logic [decode_pkg::reg_index_width-1:0] rs_index,
	output logic [decode_pkg::reg_index_width-1:0] rt_index,
	output logic [decode_pkg::reg_index_width-1:0] rd_index,
	output logic [decode_pkg::reg_index_width-1:0] shift_amount,
	output logic [5:0] alu_op,
	output logic [decode_pkg::insn_width-1:0] immediate
);

	logic funct_known;
	logic r_valid;

	always_comb begin
		case (insn.r.funct)
			decode_pkg::add_func, decode_pkg::addu_func,
			decode_pkg::sub_func, decode_pkg::subu_func,
			decode_pkg::mult_func, decode_pkg::multu_func,
			decode_pkg::div_func, decode_pkg::divu_func,
			decode_pkg::mfhi_func, decode_pkg::mflo_func,
			decode_pkg::slt_func, decode_pkg::sltu_func,
			decode_pkg::sll_func, decode_pkg::sllv_func,
			decode_pkg::srl_func, decode_pkg::srlv_func,
			decode_pkg::sra_func, decode_pkg::srav_func,
			decode_pkg::and_func, decode_pkg::or_func,
			decode_pkg::xor_func, decode_pkg::nor_func,
			decode_pkg::jalr_func, decode_pkg::jr_func: funct_known = 1'b1;
			default: funct_known = 1'b0;
		endcase
	end

	// mul_op carries a single function
	assign r_valid = (insn.r.opcode == decode_pkg::mul_op) ?
		(insn.r.funct == decode_pkg::mul_func) : funct_known;

	always_comb begin
		valid = 1'b0;
		insn_class = decode_pkg::class_none;
		rs_index = '0;
		rt_index = '0;
		rd_index = '0;
		shift_amount = '0;
		alu_op = '0;
		immediate = '0;
		case (insn.r.opcode)
			decode_pkg::r_type, decode_pkg::mul_op: begin
				valid = r_valid;
				if (r_valid) begin
					insn_class = decode_pkg::class_r;
				end
				alu_op = insn.r.funct;
				rs_index = insn.r.rs;
				rt_index = insn.r.rt;
				rd_index = insn.r.rd;
				if (insn.r.opcode == decode_pkg::r_type) begin
					case (insn.r.funct)
						decode_pkg::mult_func, decode_pkg::multu_func,
						decode_pkg::div_func, decode_pkg::divu_func: rd_index = '0;	// HI/LO target
						decode_pkg::jr_func: begin
							rt_index = '0;
							rd_index = '0;
						end
						decode_pkg::mfhi_func, decode_pkg::mflo_func: begin
							rs_index = '0;
							rt_index = '0;
						end
						decode_pkg::sll_func, decode_pkg::srl_func, decode_pkg::sra_func: begin
							rs_index = '0;
							shift_amount = insn.r.shamt;
						end
						default: ;
					endcase
				end
			end
			decode_pkg::regimm: begin
				if (insn.i.rt == decode_pkg::bltz || insn.i.rt == decode_pkg::bgez) begin
					valid = 1'b1;
					insn_class = decode_pkg::class_regimm;
					rs_index = insn.i.rs;
					rt_index = insn.i.rt;
					alu_op = {1'b0, insn.i.rt};	// Branch kind lives in rt
					immediate = {{(decode_pkg::insn_width-16){insn.i.imm16[15]}}, insn.i.imm16};
				end
			end
			decode_pkg::j, decode_pkg::jal: begin
				valid = 1'b1;
				insn_class = decode_pkg::class_j;
				alu_op = insn.j.opcode;
				immediate = {{(decode_pkg::insn_width-26){1'b0}}, insn.j.target26};
			end
			decode_pkg::addi, decode_pkg::addiu, decode_pkg::slti, decode_pkg::sltiu,
			decode_pkg::ori, decode_pkg::xori, decode_pkg::lui, decode_pkg::lw,
			decode_pkg::sw, decode_pkg::lb, decode_pkg::lbu, decode_pkg::sb,
			decode_pkg::beq, decode_pkg::bne, decode_pkg::blez, decode_pkg::bgtz: begin
				valid = 1'b1;
				insn_class = decode_pkg::class_i;
				if (insn.i.opcode != decode_pkg::lui) begin
					rs_index = insn.i.rs;
				end
				rt_index = insn.i.rt;
				rd_index = insn.i.rt;
				alu_op = insn.i.opcode;
				immediate = {{(decode_pkg::insn_width-16){insn.i.imm16[15]}}, insn.i.imm16};
			end
			default: ;	// Unknown opcode
		endcase
	end

endmodule

`default_nettype wire

// ==== decode_latch.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_latch (
	input logic clock,
	input logic reset,
	input logic enable,
	input logic [decode_pkg::insn_width-1:0] pc,
	input logic [decode_pkg::insn_width-1:0] insn,
	input logic valid,
	input decode_pkg::insn_class_t insn_class,
	input logic [decode_pkg::reg_index_width-1:0] rs_index,
	input logic [decode_pkg::reg_index_width-1:0] rt_index,
	input logic [decode_pkg::reg_index_width-1:0] rd_index,
	input logic [decode_pkg::reg_index_width-1:0] shift_amount,
	input logic [5:0] alu_op,
	input logic [decode_pkg::insn_width-1:0] immediate,
	output logic [decode_pkg::insn_width-1:0] pc_out,
	output logic [decode_pkg::insn_width-1:0] insn_out,
	output decode_pkg::insn_class_t class_out,
	output logic [decode_pkg::reg_index_width-1:0] rs_out,
	output logic [decode_pkg::reg_index_width-1:0] rt_out,
	output logic [decode_pkg::reg_index_width-1:0] rd_out,
	output logic [decode_pkg::reg_index_width-1:0] shamt_out,
	output logic [5:0] alu_op_out,
	output logic [decode_pkg::insn_width-1:0] imm_out
);

	always_ff @(posedge clock) begin
		if (reset) begin
			pc_out <= '0;
			insn_out <= '0;
			class_out <= decode_pkg::class_r;	// All-zero encoding
			rs_out <= '0;
			rt_out <= '0;
			rd_out <= '0;
			shamt_out <= '0;
			alu_op_out <= '0;
			imm_out <= '0;
		end else if (enable) begin
			pc_out <= pc;
			insn_out <= insn;
			if (valid) begin	// Unknown encodings keep the old fields
				class_out <= insn_class;
				rs_out <= rs_index;
				rt_out <= rt_index;
				rd_out <= rd_index;
				shamt_out <= shift_amount;
				alu_op_out <= alu_op;
				imm_out <= immediate;
			end
		end
	end

	// Only recognised encodings ever reach the class register
	a_class_known: assert property (@(posedge clock) disable iff (reset)
		class_out != decode_pkg::class_none);

	a_enable_known: assert property (@(posedge clock) disable iff (reset)
		!$isunknown(enable));

endmodule

`default_nettype wire

// ==== register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file #(
	parameter logic [decode_pkg::insn_width-1:0] stack_top = 32'h80120000
) (
	input logic clock,
	input logic reset,
	input logic [decode_pkg::reg_index_width-1:0] rs_index,
	input logic [decode_pkg::reg_index_width-1:0] rt_index,
	input logic write_enable,
	input logic [decode_pkg::reg_index_width-1:0] write_index,
	input logic [decode_pkg::insn_width-1:0] write_data,
	output logic [decode_pkg::insn_width-1:0] rs_data,
	output logic [decode_pkg::insn_width-1:0] rt_data
);

	localparam int data_width = decode_pkg::insn_width;

	logic [data_width-1:0] regs [decode_pkg::reg_count];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < decode_pkg::reg_count; i++) begin
				if (i == decode_pkg::stack_reg) begin
					regs[i] <= stack_top;
				end else begin
					regs[i] <= data_width'(i);	// Each register holds its index
				end
			end
		end else if (write_enable && write_index != '0) begin	// r0 stays zero
			regs[write_index] <= write_data;
		end
	end

	// Old value on a same-cycle write
	assign rs_data = regs[rs_index];
	assign rt_data = regs[rt_index];

	a_write_index_known: assert property (@(posedge clock) disable iff (reset)
		write_enable |-> !$isunknown(write_index));

	// Writeback seen by the read port one cycle later
	a_write_visible: assert property (@(posedge clock) disable iff (reset)
		(write_enable && write_index != '0 && !$isunknown(write_index))
		|=> (rs_index != $past(write_index) || rs_data == $past(write_data)));

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage #(
	parameter logic [decode_pkg::insn_width-1:0] stack_top = 32'h80120000
) (
	input logic clock,
	input logic reset,
	input logic enable,
	input logic [decode_pkg::insn_width-1:0] insn,
	input logic [decode_pkg::insn_width-1:0] pc,
	input logic write_enable,
	input logic [decode_pkg::reg_index_width-1:0] write_index,
	input logic [decode_pkg::insn_width-1:0] write_data,
	output logic [decode_pkg::insn_width-1:0] pc_out,
	output logic [decode_pkg::insn_width-1:0] insn_out,
	output decode_pkg::insn_class_t class_out,
	output logic [decode_pkg::reg_index_width-1:0] rs_out,
	output logic [decode_pkg::reg_index_width-1:0] rt_out,
	output logic [decode_pkg::reg_index_width-1:0] rd_out,
	output logic [decode_pkg::reg_index_width-1:0] shamt_out,
	output logic [5:0] alu_op_out,
	output logic [decode_pkg::insn_width-1:0] imm_out,
	output logic [decode_pkg::insn_width-1:0] rs_data,
	output logic [decode_pkg::insn_width-1:0] rt_data
);

	logic dec_valid;
	decode_pkg::insn_class_t dec_class;
	logic [decode_pkg::reg_index_width-1:0] dec_rs;
	logic [decode_pkg::reg_index_width-1:0] dec_rt;
	logic [decode_pkg::reg_index_width-1:0] dec_rd;
	logic [decode_pkg::reg_index_width-1:0] dec_shamt;
	logic [5:0] dec_alu_op;
	logic [decode_pkg::insn_width-1:0] dec_imm;

	insn_classify i_classify (
		.insn(insn),
		.valid(dec_valid),
		.insn_class(dec_class),
		.rs_index(dec_rs),
		.rt_index(dec_rt),
		.rd_index(dec_rd),
		.shift_amount(dec_shamt),
		.alu_op(dec_alu_op),
		.immediate(dec_imm)
	);

	decode_latch i_latch (
		.clock(clock),
		.reset(reset),
		.enable(enable),
		.pc(pc),
		.insn(insn),
		.valid(dec_valid),
		.insn_class(dec_class),
		.rs_index(dec_rs),
		.rt_index(dec_rt),
		.rd_index(dec_rd),
		.shift_amount(dec_shamt),
		.alu_op(dec_alu_op),
		.immediate(dec_imm),
		.pc_out(pc_out),
		.insn_out(insn_out),
		.class_out(class_out),
		.rs_out(rs_out),
		.rt_out(rt_out),
		.rd_out(rd_out),
		.shamt_out(shamt_out),
		.alu_op_out(alu_op_out),
		.imm_out(imm_out)
	);

	// Reads follow the latched indices
	register_file #(
		.stack_top(stack_top)
	) i_regs (
		.clock(clock),
		.reset(reset),
		.rs_index(rs_out),
		.rt_index(rt_out),
		.write_enable(write_enable),
		.write_index(write_index),
		.write_data(write_data),
		.rs_data(rs_data),
		.rt_data(rt_data)
	);

endmodule

`default_nettype wire

// ==== tb_decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage;

	localparam logic [31:0] stack_top = 32'h80120000;
	localparam int reset_len = 10;
	localparam int len_reset_vals = 16;
	localparam int len_r_type = 200;
	localparam int len_i_type = 200;
	localparam int len_j_type = 50;
	localparam int len_hold = 40;
	localparam int len_write = 64;
	localparam int timeout_limit = reset_len + len_reset_vals + len_r_type + len_i_type
		+ len_j_type + len_hold + len_write + 50;

	logic clock, reset, enable, write_enable;
	logic [31:0] insn, pc, write_data;
	logic [4:0] write_index;
	logic [31:0] pc_out, insn_out, imm_out, rs_data, rt_data;
	decode_pkg::insn_class_t class_out;
	logic [4:0] rs_out, rt_out, rd_out, shamt_out;
	logic [5:0] alu_op_out;

	// Expected latch contents and shadow register file
	logic [31:0] exp_pc, exp_insn, exp_imm;
	decode_pkg::insn_class_t exp_class;
	logic [4:0] exp_rs, exp_rt, exp_rd, exp_shamt;
	logic [5:0] exp_alu_op;
	logic [31:0] shadow [32];

	logic [31:0] lfsr = 32'haa7b;
	int errors = 0;
	int cycle_count = 0;

	logic [5:0] r_funcs [24] = '{
		decode_pkg::add_func, decode_pkg::addu_func, decode_pkg::sub_func,
		decode_pkg::subu_func, decode_pkg::mult_func, decode_pkg::multu_func,
		decode_pkg::div_func, decode_pkg::divu_func, decode_pkg::mfhi_func,
		decode_pkg::mflo_func, decode_pkg::slt_func, decode_pkg::sltu_func,
		decode_pkg::sll_func, decode_pkg::sllv_func, decode_pkg::srl_func,
		decode_pkg::srlv_func, decode_pkg::sra_func, decode_pkg::srav_func,
		decode_pkg::and_func, decode_pkg::or_func, decode_pkg::xor_func,
		decode_pkg::nor_func, decode_pkg::jalr_func, decode_pkg::jr_func};
	logic [5:0] i_opcodes [16] = '{
		decode_pkg::addi, decode_pkg::addiu, decode_pkg::slti, decode_pkg::sltiu,
		decode_pkg::ori, decode_pkg::xori, decode_pkg::lui, decode_pkg::lw,
		decode_pkg::sw, decode_pkg::lb, decode_pkg::lbu, decode_pkg::sb,
		decode_pkg::beq, decode_pkg::bne, decode_pkg::blez, decode_pkg::bgtz};
	logic [5:0] bad_opcodes [5] = '{6'h3f, 6'h11, 6'h12, 6'h13, 6'h14};

	decode_stage #(
		.stack_top(stack_top)
	) i_dut (
		.clock(clock), .reset(reset), .enable(enable), .insn(insn), .pc(pc),
		.write_enable(write_enable), .write_index(write_index), .write_data(write_data),
		.pc_out(pc_out), .insn_out(insn_out), .class_out(class_out),
		.rs_out(rs_out), .rt_out(rt_out), .rd_out(rd_out), .shamt_out(shamt_out),
		.alu_op_out(alu_op_out), .imm_out(imm_out), .rs_data(rs_data), .rt_data(rt_data)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic fb;
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic void decode_model(input logic [31:0] w, output logic ok,
		output decode_pkg::insn_class_t cls, output logic [4:0] rs, output logic [4:0] rt,
		output logic [4:0] rd, output logic [4:0] sh, output logic [5:0] op,
		output logic [31:0] imm);
		logic [5:0] opc;
		logic [5:0] f;
		opc = w[31:26];
		f = w[5:0];
		rs = w[25:21];
		rt = w[20:16];
		rd = w[15:11];
		sh = '0;
		op = '0;
		imm = '0;
		ok = 1'b0;
		cls = decode_pkg::class_none;
		if (opc == 6'd0) begin
			ok = (f inside {r_funcs});
			cls = decode_pkg::class_r;
			op = f;
			if (f inside {decode_pkg::mult_func, decode_pkg::multu_func,
					decode_pkg::div_func, decode_pkg::divu_func})
				rd = '0;
			if (f == decode_pkg::jr_func) begin
				rd = '0;
				rt = '0;
			end
			if (f inside {decode_pkg::mfhi_func, decode_pkg::mflo_func}) begin
				rs = '0;
				rt = '0;
			end
			if (f inside {decode_pkg::sll_func, decode_pkg::srl_func, decode_pkg::sra_func}) begin
				rs = '0;
				sh = w[10:6];
			end
		end else if (opc == decode_pkg::mul_op) begin
			ok = (f == decode_pkg::mul_func);
			cls = decode_pkg::class_r;
			op = f;
		end else if (opc == decode_pkg::regimm) begin
			ok = (rt inside {decode_pkg::bltz, decode_pkg::bgez});
			cls = decode_pkg::class_regimm;
			rd = '0;
			op = {1'b0, rt};
			imm = {{16{w[15]}}, w[15:0]};
		end else if (opc inside {decode_pkg::j, decode_pkg::jal}) begin
			ok = 1'b1;
			cls = decode_pkg::class_j;
			rs = '0;
			rt = '0;
			rd = '0;
			op = opc;
			imm = {6'b0, w[25:0]};
		end else if (opc inside {i_opcodes}) begin
			ok = 1'b1;
			cls = decode_pkg::class_i;
			rd = rt;
			if (opc == decode_pkg::lui)
				rs = '0;
			op = opc;
			imm = {{16{w[15]}}, w[15:0]};
		end
	endfunction

	always @(posedge clock) begin
		logic ok;
		decode_pkg::insn_class_t cls;
		logic [4:0] rs, rt, rd, sh;
		logic [5:0] op;
		logic [31:0] imm;
		decode_model(insn, ok, cls, rs, rt, rd, sh, op, imm);
		if (reset) begin
			{exp_pc, exp_insn, exp_imm} <= '0;
			{exp_rs, exp_rt, exp_rd, exp_shamt, exp_alu_op} <= '0;
			exp_class <= decode_pkg::class_r;
			for (int k = 0; k < 32; k++)
				shadow[k] <= (k == 29) ? stack_top : 32'(k);
		end else begin
			if (enable) begin
				exp_pc <= pc;
				exp_insn <= insn;
				if (ok) begin
					exp_class <= cls;
					{exp_rs, exp_rt, exp_rd, exp_shamt, exp_alu_op, exp_imm} <=
						{rs, rt, rd, sh, op, imm};
				end
			end
			if (write_enable && write_index != 5'd0)
				shadow[write_index] <= write_data;
		end
	end

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		$display("mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
		errors++;
	endtask

	a_pc: assert property (@(posedge clock) disable iff (reset) pc_out == exp_pc)
		else report_mismatch("pc_out", $sampled(pc_out), $sampled(exp_pc));
	a_insn: assert property (@(posedge clock) disable iff (reset) insn_out == exp_insn)
		else report_mismatch("insn_out", $sampled(insn_out), $sampled(exp_insn));
	a_class: assert property (@(posedge clock) disable iff (reset) class_out == exp_class)
		else report_mismatch("class_out", $sampled(class_out), $sampled(exp_class));
	a_rs: assert property (@(posedge clock) disable iff (reset) rs_out == exp_rs)
		else report_mismatch("rs_out", $sampled(rs_out), $sampled(exp_rs));
	a_rt: assert property (@(posedge clock) disable iff (reset) rt_out == exp_rt)
		else report_mismatch("rt_out", $sampled(rt_out), $sampled(exp_rt));
	a_rd: assert property (@(posedge clock) disable iff (reset) rd_out == exp_rd)
		else report_mismatch("rd_out", $sampled(rd_out), $sampled(exp_rd));
	a_shamt: assert property (@(posedge clock) disable iff (reset) shamt_out == exp_shamt)
		else report_mismatch("shamt_out", $sampled(shamt_out), $sampled(exp_shamt));
	a_alu_op: assert property (@(posedge clock) disable iff (reset) alu_op_out == exp_alu_op)
		else report_mismatch("alu_op_out", $sampled(alu_op_out), $sampled(exp_alu_op));
	a_imm: assert property (@(posedge clock) disable iff (reset) imm_out == exp_imm)
		else report_mismatch("imm_out", $sampled(imm_out), $sampled(exp_imm));
	a_rs_data: assert property (@(posedge clock) disable iff (reset) rs_data == shadow[rs_out])
		else report_mismatch("rs_data", $sampled(rs_data), $sampled(shadow[rs_out]));
	a_rt_data: assert property (@(posedge clock) disable iff (reset) rt_data == shadow[rt_out])
		else report_mismatch("rt_data", $sampled(rt_data), $sampled(shadow[rt_out]));

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count > timeout_limit) begin
			$display("timeout: run did not finish within %0d cycles", timeout_limit);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic report_test(input string name, input int errors_before);
		$display("test %s: %0d errors", name, errors - errors_before);
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] d;
		int mark;
		int tests;
		tests = 0;
		reset = 1'b1;
		enable = 1'b0;
		insn = '0;
		pc = '0;
		write_enable = 1'b0;
		write_index = '0;
		write_data = '0;
		repeat (reset_len) @(posedge clock);
		reset <= 1'b0;

		mark = errors;
		for (int k = 0; k < len_reset_vals; k++) begin	// add r?, rs, rt
			@(posedge clock);
			enable <= 1'b1;
			pc <= 32'h1000 + 32'(4 * k);
			insn <= {6'd0, 5'(2 * k), 5'(2 * k + 1), 5'd3, 5'd0, decode_pkg::add_func};
		end
		@(posedge clock);
		report_test("register reset values", mark);
		tests++;

		mark = errors;
		for (int k = 0; k < len_r_type; k++) begin
			r = random_bits(32);
			@(posedge clock);
			pc <= pc + 32'd4;
			if (r[31:29] == 3'd0)
				insn <= {decode_pkg::mul_op, r[25:6], decode_pkg::mul_func};
			else
				insn <= {6'd0, r[25:6], r_funcs[r[28:26] * 3 + int'(r[2:0]) % 3]};
		end
		@(posedge clock);
		report_test("r-type decode", mark);
		tests++;

		mark = errors;
		for (int k = 0; k < len_i_type; k++) begin
			r = random_bits(32);
			@(posedge clock);
			pc <= pc + 32'd4;
			if (r[31:29] == 3'd0)
				insn <= {decode_pkg::regimm, r[25:21], 4'd0, r[16], r[15:0]};
			else
				insn <= {i_opcodes[r[29:26]], r[25:0]};
		end
		@(posedge clock);
		report_test("i-type and regimm decode", mark);
		tests++;

		mark = errors;
		for (int k = 0; k < len_j_type; k++) begin
			r = random_bits(27);
			@(posedge clock);
			pc <= pc + 32'd4;
			insn <= {r[26] ? decode_pkg::jal : decode_pkg::j, r[25:0]};
		end
		@(posedge clock);
		report_test("j-type decode", mark);
		tests++;

		mark = errors;
		for (int k = 0; k < len_hold; k++) begin
			r = random_bits(32);
			@(posedge clock);
			pc <= pc + 32'd4;
			enable <= (k >= len_hold / 2);	// First half held
			if (k < len_hold / 2)
				insn <= {i_opcodes[r[29:26]], r[25:0]};	// Valid words must not get through
			else if (k % 4 == 3)
				insn <= {6'd0, r[25:6], 6'b111111};	// Unknown function
			else
				insn <= {bad_opcodes[k % 5], r[25:0]};
		end
		@(posedge clock);
		report_test("enable and unknown opcodes", mark);
		tests++;

		mark = errors;
		for (int k = 0; k < len_write; k++) begin
			r = random_bits(5);
			d = random_bits(32);
			@(posedge clock);
			enable <= 1'b1;
			write_enable <= 1'b1;
			write_index <= (k % 4 == 0) ? 5'd0 : r[4:0];
			write_data <= d;
			insn <= {6'd0, (k % 4 == 0) ? 5'd0 : r[4:0], write_index, 5'd1, 5'd0,
				decode_pkg::or_func};
		end
		@(posedge clock);
		write_enable <= 1'b0;
		repeat (2) @(posedge clock);
		report_test("write port", mark);
		tests++;

		$display("summary: %0d tests, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== decode_stage.f ====
decode_pkg.sv
insn_classify.sv
decode_latch.sv
register_file.sv
decode_stage.sv
tb_decode_stage.sv

// ==== Makefile ====
# Verilator build for the decode stage testbench

VERILATOR ?= verilator
TOP ?= tb_decode_stage
FILELIST ?= decode_stage.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "simulation failed" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
